// File: src/ext_harness_pkg.sv
//////////////////////////////////////////////////////////////////////
// register map and sizing for the external peripheral block
// FIFO_DEPTH must be a power of two and fit in LEVEL_W bits
//////////////////////////////////////////////////////////////////////

package ext_harness_pkg;

  // bus geometry
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned REG_ADDR_W = 8;
  localparam int unsigned REGION_LSB = 4;
  localparam int unsigned OFFSET_W   = 2;
  localparam int unsigned REGION_W   = REG_ADDR_W - REGION_LSB;

  // region numbers, bits 7 to 4 of the byte address
  localparam logic [REGION_W-1:0] REGION_POWER = 4'd0;
  localparam logic [REGION_W-1:0] REGION_FIFO  = 4'd1;

  // power domains and switch cell latency in cycles
  localparam int unsigned NUM_DOMAINS        = 4;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // FIFO sizing
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned LEVEL_W    = 4;
  localparam logic [LEVEL_W-1:0] WATERMARK_RESET = 4'd4;

  // power block word offsets
  localparam logic [OFFSET_W-1:0] OFS_PWR_SWITCH  = 2'd0;
  localparam logic [OFFSET_W-1:0] OFS_PWR_ISO_RST = 2'd1;
  localparam logic [OFFSET_W-1:0] OFS_PWR_STATUS  = 2'd2;
  localparam int unsigned STATUS_DONE_BIT = 8;

  // FIFO block word offsets
  localparam logic [OFFSET_W-1:0] OFS_FIFO_DATA  = 2'd0;
  localparam logic [OFFSET_W-1:0] OFS_FIFO_LEVEL = 2'd1;
  localparam logic [OFFSET_W-1:0] OFS_FIFO_WMARK = 2'd2;

  // interrupt vector
  localparam int unsigned NUM_IRQ   = 2;
  localparam int unsigned IRQ_FIFO  = 0;
  localparam int unsigned IRQ_POWER = 1;

endpackage

// File: src/reg_bus_if.sv
//////////////////////////////////////////////////////////////////////
// one-cycle register bus, no back-pressure
// target answers every req exactly one cycle later
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface reg_bus_if;
  import ext_harness_pkg::*;

  logic                req;
  logic                we;
  logic [OFFSET_W-1:0] offset;
  logic [DATA_W-1:0]   wdata;
  logic                rvalid;
  logic [DATA_W-1:0]   rdata;
  logic                error;

  modport decoder (output req, we, offset, wdata, input rvalid, rdata, error);
  modport target (input req, we, offset, wdata, output rvalid, rdata, error);

endinterface

// File: src/periph_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// steers one request per cycle to the power or FIFO block
// unmapped regions answer with error and zero data, address bits 1:0 ignored
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module periph_addr_decode (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [ext_harness_pkg::REG_ADDR_W-1:0] addr_i,
  input  logic [ext_harness_pkg::DATA_W-1:0]     wdata_i,
  output logic                                  rvalid_o,
  output logic [ext_harness_pkg::DATA_W-1:0]     rdata_o,
  output logic                                  error_o,
  reg_bus_if.decoder                            pwr_bus,
  reg_bus_if.decoder                            fifo_bus
);
  import ext_harness_pkg::*;

  logic [REGION_W-1:0] region;
  logic [OFFSET_W-1:0] offset;
  logic                pwr_hit;
  logic                fifo_hit;
  logic                pwr_sel_q;
  logic                fifo_sel_q;
  logic                unmapped_q;

  assign region   = addr_i[REG_ADDR_W-1:REGION_LSB];
  assign offset   = addr_i[REGION_LSB-1 -: OFFSET_W];
  assign pwr_hit  = req_i && (region == REGION_POWER);
  assign fifo_hit = req_i && (region == REGION_FIFO);

  // only the selected target sees req
  assign pwr_bus.req     = pwr_hit;
  assign pwr_bus.we      = we_i;
  assign pwr_bus.offset  = offset;
  assign pwr_bus.wdata   = wdata_i;
  assign fifo_bus.req    = fifo_hit;
  assign fifo_bus.we     = we_i;
  assign fifo_bus.offset = offset;
  assign fifo_bus.wdata  = wdata_i;

  // remember who owes the response next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pwr_sel_q  <= 1'b0;
      fifo_sel_q <= 1'b0;
      unmapped_q <= 1'b0;
    end else begin
      pwr_sel_q  <= pwr_hit;
      fifo_sel_q <= fifo_hit;
      unmapped_q <= req_i && !pwr_hit && !fifo_hit;
    end
  end

  always_comb begin
    rvalid_o = unmapped_q;
    rdata_o  = '0;
    error_o  = unmapped_q;
    if (pwr_sel_q) begin
      rvalid_o = pwr_bus.rvalid;
      rdata_o  = pwr_bus.rdata;
      error_o  = pwr_bus.error;
    end else if (fifo_sel_q) begin
      rvalid_o = fifo_bus.rvalid;
      rdata_o  = fifo_bus.rdata;
      error_o  = fifo_bus.error;
    end
  end

endmodule

// File: src/power_ctrl_regs.sv
//////////////////////////////////////////////////////////////////////
// power switch, isolation and reset control for external domains
// all outputs active low; domains come out of reset off and isolated
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module power_ctrl_regs (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic [ext_harness_pkg::NUM_DOMAINS-1:0] ack_n_i,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] switch_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] iso_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] rst_n_o,
  output logic                                   done_o,
  reg_bus_if.target                              bus
);
  import ext_harness_pkg::*;

  logic [NUM_DOMAINS-1:0]   switch_q;
  logic [2*NUM_DOMAINS-1:0] iso_rst_q;
  logic                     busy_q;
  logic                     done_q;
  logic                     wr_switch;
  logic                     wr_iso_rst;
  logic                     wr_status;
  logic                     settled;
  logic [DATA_W-1:0]        rdata_d;
  logic                     error_d;

  assign wr_switch  = bus.req && bus.we && (bus.offset == OFS_PWR_SWITCH);
  assign wr_iso_rst = bus.req && bus.we && (bus.offset == OFS_PWR_ISO_RST);
  assign wr_status  = bus.req && bus.we && (bus.offset == OFS_PWR_STATUS);

  // acks caught up with the last switch request, unless a new one lands now
  assign settled = busy_q && !wr_switch && (ack_n_i == switch_n_o);

  assign switch_n_o = ~switch_q;
  assign iso_n_o    = iso_rst_q[NUM_DOMAINS-1:0];
  assign rst_n_o    = iso_rst_q[2*NUM_DOMAINS-1:NUM_DOMAINS];
  assign done_o     = done_q;

  always_comb begin
    rdata_d = '0;
    error_d = 1'b0;
    case (bus.offset)
      OFS_PWR_SWITCH: begin
        if (!bus.we) rdata_d[NUM_DOMAINS-1:0] = switch_q;
      end
      OFS_PWR_ISO_RST: begin
        if (!bus.we) rdata_d[2*NUM_DOMAINS-1:0] = iso_rst_q;
      end
      OFS_PWR_STATUS: begin
        if (!bus.we) begin
          rdata_d[NUM_DOMAINS-1:0]  = ~ack_n_i;
          rdata_d[STATUS_DONE_BIT] = done_q;
        end
      end
      default: error_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      switch_q   <= '0;
      iso_rst_q  <= '0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
      if (wr_switch) switch_q <= bus.wdata[NUM_DOMAINS-1:0];
      if (wr_iso_rst) iso_rst_q <= bus.wdata[2*NUM_DOMAINS-1:0];
      if (wr_switch) begin
        busy_q <= 1'b1;
      end else if (settled) begin
        busy_q <= 1'b0;
      end
      // a fresh completion wins over a clear in the same cycle
      if (settled) begin
        done_q <= 1'b1;
      end else if (wr_status) begin
        done_q <= 1'b0;
      end
    end
  end

  // response word, only sampled while rvalid is high
  always_ff @(posedge clk_i) begin
    bus.rdata <= rdata_d;
    bus.error <= error_d;
  end

endmodule

// File: src/power_switch_model.sv
//////////////////////////////////////////////////////////////////////
// behavioural stand-in for power switch cells
// ack follows the request after SWITCH_ACK_LATENCY rising edges
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module power_switch_model (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic [ext_harness_pkg::NUM_DOMAINS-1:0] switch_n_i,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] ack_n_o
);
  import ext_harness_pkg::*;

  logic [NUM_DOMAINS-1:0] chain_q [SWITCH_ACK_LATENCY];

  // all stages off at reset, matching the switch outputs
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        chain_q[i] <= '1;
      end
    end else begin
      chain_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign ack_n_o = chain_q[SWITCH_ACK_LATENCY-1];

endmodule

// File: src/iffifo_periph.sv
//////////////////////////////////////////////////////////////////////
// credit-fed receive FIFO popped by register reads
// producer must hold a credit to push; a push while full is dropped
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module iffifo_periph (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              push_i,
  input  logic [ext_harness_pkg::DATA_W-1:0] push_data_i,
  output logic                              credit_o,
  output logic                              irq_o,
  output logic                              dma_rx_o,
  reg_bus_if.target                         bus
);
  import ext_harness_pkg::*;

  logic [DATA_W-1:0]  mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [LEVEL_W-1:0] level_q;
  logic [LEVEL_W-1:0] wmark_q;
  logic               empty;
  logic               full;
  logic               push_ok;
  logic               pop;
  logic               wr_wmark;
  logic [DATA_W-1:0]  rdata_d;
  logic               error_d;

  assign empty    = (level_q == '0);
  assign full     = (level_q == LEVEL_W'(FIFO_DEPTH));
  assign push_ok  = push_i && !full;
  assign pop      = bus.req && !bus.we && (bus.offset == OFS_FIFO_DATA) && !empty;
  assign wr_wmark = bus.req && bus.we && (bus.offset == OFS_FIFO_WMARK);

  assign irq_o    = (level_q >= wmark_q);
  assign dma_rx_o = !empty;

  // writes to DATA and LEVEL are accepted and ignored
  always_comb begin
    rdata_d = '0;
    error_d = 1'b0;
    case (bus.offset)
      OFS_FIFO_DATA: begin
        if (!bus.we) begin
          if (empty) error_d = 1'b1;
          else rdata_d = mem_q[rd_ptr_q];
        end
      end
      OFS_FIFO_LEVEL: begin
        if (!bus.we) rdata_d[LEVEL_W-1:0] = level_q;
      end
      OFS_FIFO_WMARK: begin
        if (!bus.we) rdata_d[LEVEL_W-1:0] = wmark_q;
      end
      default: error_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      wmark_q    <= WATERMARK_RESET;
      credit_o   <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
      // credit goes back together with the popped word
      credit_o   <= pop;
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
      if (wr_wmark) wmark_q <= bus.wdata[LEVEL_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= push_data_i;
    bus.rdata <= rdata_d;
    bus.error <= error_d;
  end

endmodule

// File: src/ext_periph_top.sv
//////////////////////////////////////////////////////////////////////
// external peripheral block: power control and receive FIFO
// one register access per cycle, response exactly one cycle later
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ext_periph_top (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   reg_req_i,
  input  logic                                   reg_we_i,
  input  logic [ext_harness_pkg::REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [ext_harness_pkg::DATA_W-1:0]      reg_wdata_i,
  input  logic                                   push_i,
  input  logic [ext_harness_pkg::DATA_W-1:0]      push_data_i,
  output logic                                   reg_rvalid_o,
  output logic [ext_harness_pkg::DATA_W-1:0]      reg_rdata_o,
  output logic                                   reg_error_o,
  output logic                                   credit_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] pwr_switch_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] pwr_iso_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] pwr_rst_n_o,
  output logic [ext_harness_pkg::NUM_IRQ-1:0]     irq_o,
  output logic                                   dma_rx_o
);
  import ext_harness_pkg::*;

  logic [NUM_DOMAINS-1:0] switch_n;
  logic [NUM_DOMAINS-1:0] ack_n;
  logic                   pwr_done;
  logic                   fifo_irq;

  reg_bus_if pwr_bus ();
  reg_bus_if fifo_bus ();

  periph_addr_decode periph_addr_decode_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (reg_req_i),
    .we_i     (reg_we_i),
    .addr_i   (reg_addr_i),
    .wdata_i  (reg_wdata_i),
    .rvalid_o (reg_rvalid_o),
    .rdata_o  (reg_rdata_o),
    .error_o  (reg_error_o),
    .pwr_bus  (pwr_bus.decoder),
    .fifo_bus (fifo_bus.decoder)
  );

  power_ctrl_regs power_ctrl_regs_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ack_n_i    (ack_n),
    .switch_n_o (switch_n),
    .iso_n_o    (pwr_iso_n_o),
    .rst_n_o    (pwr_rst_n_o),
    .done_o     (pwr_done),
    .bus        (pwr_bus.target)
  );

  // switch cells close the loop back into the status register
  power_switch_model power_switch_model_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .switch_n_i (switch_n),
    .ack_n_o    (ack_n)
  );

  iffifo_periph iffifo_periph_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .push_i      (push_i),
    .push_data_i (push_data_i),
    .credit_o    (credit_o),
    .irq_o       (fifo_irq),
    .dma_rx_o    (dma_rx_o),
    .bus         (fifo_bus.target)
  );

  assign pwr_switch_n_o = switch_n;

  // interrupt vector
  always_comb begin
    irq_o            = '0;
    irq_o[IRQ_FIFO]  = fifo_irq;
    irq_o[IRQ_POWER] = pwr_done;
  end

endmodule

// File: tb/tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// 40 ns clock, reset held low for two rising edges
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int unsigned HALF_PERIOD  = 20;
  localparam int unsigned RESET_CYCLES = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the active edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_ext_periph_top.sv
//////////////////////////////////////////////////////////////////////
// testbench for ext_periph_top, run from the project root
// register cases come from tb/ext_periph_cases.txt, five hex words each
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_ext_periph_top;
  import ext_harness_pkg::*;

  localparam int unsigned MAX_CASES   = 64;
  localparam int unsigned ACK_LAT     = 15;
  localparam int unsigned WAIT_LIMIT  = 20;
  localparam logic [7:0]  ADDR_SWITCH = 8'h00;
  localparam logic [7:0]  ADDR_ISO    = 8'h04;
  localparam logic [7:0]  ADDR_STATUS = 8'h08;
  localparam logic [7:0]  ADDR_DATA   = 8'h10;
  localparam logic [7:0]  ADDR_LEVEL  = 8'h14;
  localparam logic [7:0]  ADDR_WMARK  = 8'h18;

  logic        clk;
  logic        arst_n;
  logic        reg_req_i;
  logic        reg_we_i;
  logic [7:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic        push_i;
  logic [31:0] push_data_i;
  logic        reg_rvalid_o;
  logic [31:0] reg_rdata_o;
  logic        reg_error_o;
  logic        credit_o;
  logic [3:0]  pwr_switch_n_o;
  logic [3:0]  pwr_iso_n_o;
  logic [3:0]  pwr_rst_n_o;
  logic [1:0]  irq_o;
  logic        dma_rx_o;

  logic [31:0] case_mem [0:MAX_CASES*5-1];
  logic [31:0] fifo_q [$];
  integer      seed;
  int          checks;
  int          errors;
  int          timeouts;
  // producer side model
  int          level;
  int          wmark;
  int          credits;

  tb_clk_gen clk_gen_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  ext_periph_top dut_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .reg_req_i      (reg_req_i),
    .reg_we_i       (reg_we_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .push_i         (push_i),
    .push_data_i    (push_data_i),
    .reg_rvalid_o   (reg_rvalid_o),
    .reg_rdata_o    (reg_rdata_o),
    .reg_error_o    (reg_error_o),
    .credit_o       (credit_o),
    .pwr_switch_n_o (pwr_switch_n_o),
    .pwr_iso_n_o    (pwr_iso_n_o),
    .pwr_rst_n_o    (pwr_rst_n_o),
    .irq_o          (irq_o),
    .dma_rx_o       (dma_rx_o)
  );

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // called just after a falling edge; returns on the response edge
  task automatic bus_access(input logic we, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    @(negedge clk);
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
    compare($sformatf("rvalid for addr %h", addr), 1, reg_rvalid_o);
    rdata = reg_rdata_o;
    err   = reg_error_o;
  endtask

  task automatic check_flags(input string where);
    compare($sformatf("%s irq fifo", where), level >= wmark, irq_o[IRQ_FIFO]);
    compare($sformatf("%s dma_rx", where), level != 0, dma_rx_o);
  endtask

  task automatic check_level(input string where);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, ADDR_LEVEL, '0, rdata, err);
    compare($sformatf("%s level", where), level, rdata);
    compare($sformatf("%s level error", where), 0, err);
  endtask

  task automatic set_watermark(input int value);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, ADDR_WMARK, value, rdata, err);
    compare("watermark write error", 0, err);
    wmark = value;
    check_flags($sformatf("watermark %0d", value));
  endtask

  task automatic push_word(input logic [31:0] data);
    push_i      = 1'b1;
    push_data_i = data;
    @(negedge clk);
    push_i = 1'b0;
    // level counts the push one cycle later
    level++;
    credits--;
    // credits come back only through credit_o
    if (credit_o) credits++;
    fifo_q.push_back(data);
    check_flags($sformatf("push %0d", level));
  endtask

  task automatic pop_word();
    logic [31:0] expected;
    logic [31:0] rdata;
    logic        err;
    expected = fifo_q.pop_front();
    bus_access(1'b0, ADDR_DATA, '0, rdata, err);
    compare("pop data", expected, rdata);
    compare("pop error", 0, err);
    compare("credit with pop", 1, credit_o);
    level--;
    if (credit_o) credits++;
    check_flags($sformatf("pop to %0d", level));
    @(negedge clk);
    compare("credit single pulse", 0, credit_o);
    check_level("after pop");
  endtask

  task automatic check_reset_values();
    compare("reset rvalid", 0, reg_rvalid_o);
    compare("reset rdata", 0, reg_rdata_o);
    compare("reset error", 0, reg_error_o);
    compare("reset credit", 0, credit_o);
    compare("reset irq", 0, irq_o);
    compare("reset dma_rx", 0, dma_rx_o);
    compare("reset switch_n", 4'hf, pwr_switch_n_o);
    compare("reset iso_n", 0, pwr_iso_n_o);
    compare("reset rst_n", 0, pwr_rst_n_o);
  endtask

  task automatic apply_cases();
    int          idx;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    string       name;
    for (idx = 0; idx < MAX_CASES; idx++) begin
      op    = case_mem[idx*5];
      addr  = case_mem[idx*5+1];
      wdata = case_mem[idx*5+2];
      if ($isunknown(op)) begin
        errors++;
        $display("case file unreadable or missing its end marker at case %0d", idx);
        return;
      end
      if (op == 32'd2) return;
      name = $sformatf("case %0d", idx);
      bus_access(op[0], addr[7:0], wdata, rdata, err);
      compare($sformatf("%s rdata", name), case_mem[idx*5+3], rdata);
      compare($sformatf("%s error", name), case_mem[idx*5+4], err);
      if (op[0] && addr[7:0] == ADDR_ISO) begin
        compare($sformatf("%s iso_n", name), wdata[3:0], pwr_iso_n_o);
        compare($sformatf("%s rst_n", name), wdata[7:4], pwr_rst_n_o);
      end
      // no second response
      @(negedge clk);
      compare($sformatf("%s rvalid idle", name), 0, reg_rvalid_o);
    end
    errors++;
    $display("case file has no end marker within %0d cases", MAX_CASES);
  endtask

  task automatic power_on_sequence();
    logic [3:0]  mask;
    logic [3:0]  mask_n;
    logic [31:0] rdata;
    logic        err;
    bit          seen;
    int          n;
    mask   = 4'b0101;
    mask_n = ~mask;
    bus_access(1'b1, ADDR_SWITCH, mask, rdata, err);
    compare("switch write error", 0, err);
    compare("switch_n after write", mask_n, pwr_switch_n_o);
    // a read samples ack at its request edge, ack lags switch by ACK_LAT edges
    seen = 0;
    n    = 0;
    while (!seen && n < 4 * ACK_LAT) begin
      bus_access(1'b0, ADDR_STATUS, '0, rdata, err);
      n++;
      if (rdata[3:0] == mask) seen = 1;
      else compare("status before ack", 0, rdata);
    end
    if (!seen) begin
      timeouts++;
      $display("timeout: switch acknowledge never showed up in STATUS");
      return;
    end
    compare("status ack read count", ACK_LAT + 1, n);
    compare("status at ack", mask, rdata);
    n = 0;
    while (!irq_o[IRQ_POWER] && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!irq_o[IRQ_POWER]) begin
      timeouts++;
      $display("timeout: power done interrupt never rose");
      return;
    end
    bus_access(1'b0, ADDR_STATUS, '0, rdata, err);
    compare("status done", 32'(mask) | 32'h100, rdata);
    bus_access(1'b1, ADDR_STATUS, '0, rdata, err);
    compare("power irq after clear", 0, irq_o[IRQ_POWER]);
    bus_access(1'b0, ADDR_STATUS, '0, rdata, err);
    compare("status after clear", mask, rdata);
  endtask

  task automatic producer_sequence();
    logic [31:0] rdata;
    logic        err;
    int          pushed;
    check_flags("idle");
    pushed = 0;
    while (credits > 0 && pushed < FIFO_DEPTH) begin
      push_word($random(seed));
      pushed++;
    end
    compare("credits used", 0, credits);
    check_level("after pushes");
    set_watermark(8);
    set_watermark(9);
    set_watermark(2);
    while (fifo_q.size() > 0) pop_word();
    bus_access(1'b0, ADDR_DATA, '0, rdata, err);
    compare("empty read data", 0, rdata);
    compare("empty read error", 1, err);
    compare("empty read credit", 0, credit_o);
    set_watermark(0);
    set_watermark(WATERMARK_RESET);
    compare("credits returned", FIFO_DEPTH, credits);
  endtask

  initial begin
    int n;
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    push_i      = 1'b0;
    push_data_i = '0;
    seed        = 32'h8077;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    level       = 0;
    wmark       = WATERMARK_RESET;
    credits     = FIFO_DEPTH;
    $readmemh("tb/ext_periph_cases.txt", case_mem);
    n = 0;
    while (arst_n !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (arst_n !== 1'b1) begin
      timeouts++;
      $display("timeout: reset was never released");
    end else begin
      @(negedge clk);
      check_reset_values();
      apply_cases();
      power_on_sequence();
      if (timeouts == 0) producer_sequence();
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb/ext_periph_cases.txt
// register cases, all fields hex, one case per line
// op (0 read, 1 write, 2 end)  address  write data  expected read data  expected error
0 18 00000000 00000004 0
1 18 00000006 00000000 0
0 18 00000000 00000006 0
1 18 00000004 00000000 0
0 14 00000000 00000000 0
0 10 00000000 00000000 1
0 1c 00000000 00000000 1
1 1c 12345678 00000000 1
0 18 00000000 00000004 0
0 0c 00000000 00000000 1
1 0c 0000000f 00000000 1
0 20 00000000 00000000 1
1 24 deadbeef 00000000 1
0 f8 00000000 00000000 1
0 00 00000000 00000000 0
0 08 00000000 00000000 0
1 04 0000000f 00000000 0
0 04 00000000 0000000f 0
1 04 000000a5 00000000 0
0 04 00000000 000000a5 0
1 04 ffffff3c 00000000 0
0 04 00000000 0000003c 0
1 04 00000000 00000000 0
0 04 00000000 00000000 0
0 00 00000000 00000000 0
2 00 00000000 00000000 0

// File: files.f
src/ext_harness_pkg.sv
src/reg_bus_if.sv
src/periph_addr_decode.sv
src/power_ctrl_regs.sv
src/power_switch_model.sv
src/iffifo_periph.sv
src/ext_periph_top.sv
tb/tb_clk_gen.sv
tb/tb_ext_periph_top.sv

// File: Bender.yml
package:
  name: ext_periph

sources:
  - files:
      - src/ext_harness_pkg.sv
      - src/reg_bus_if.sv
      - src/periph_addr_decode.sv
      - src/power_ctrl_regs.sv
      - src/power_switch_model.sv
      - src/iffifo_periph.sv
      - src/ext_periph_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_ext_periph_top.sv
